// ==== include/weight_mem_defs.svh ====
`ifndef WEIGHT_MEM_DEFS_SVH
`define WEIGHT_MEM_DEFS_SVH

// Array dimension, weights per word and words per tile
`define WB_N_DIM 4
`define WB_WEIGHT_W 8

// 4096 words over two banks
`define WB_ADDR_W 12
`define WB_ROW_ADDR_W 9
`define WB_BANK_ROWS (1 << `WB_ROW_ADDR_W)

// Codes on the 3-bit mode input
`define WB_MODE_FC 3'd0
`define WB_MODE_CNN 3'd1

`endif

// ==== logic/weight_bank.sv ====
`include "weight_mem_defs.svh"

module weight_bank import weight_mem_pkg::*; (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input logic [`WB_ROW_ADDR_W-1:0] wr_row,
	input logic [1:0] wr_lane,
	input weight_word_t wr_data,
	input logic rd_en,
	input logic [`WB_ROW_ADDR_W-1:0] rd_row,
	output weight_tile_t rd_tile
);

	// One memory per lane, each 512 words deep
	weight_word_t lane_mem [`WB_N_DIM][`WB_BANK_ROWS];

	// A write touches a single lane of the addressed row
	always_ff @(posedge clk) begin
		if (wr_en) begin
			lane_mem[wr_lane][wr_row] <= wr_data;
		end
	end

	// All lanes of the row come out together one cycle after rd_en
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rd_tile <= '0;
		end else if (rd_en) begin
			for (int lane = 0; lane < `WB_N_DIM; lane++) begin
				rd_tile[lane] <= lane_mem[lane][rd_row];
			end
		end
	end

	// An unknown address on a write strobe would corrupt an unknown location
	a_wr_addr_known: assert property (
		@(posedge clk) disable iff (!reset)
		wr_en |-> !$isunknown({wr_lane, wr_row})
	) else $error("weight_bank write address unknown while wr_en is high");

endmodule

// ==== logic/weight_buffer.sv ====
`include "weight_mem_defs.svh"

module weight_buffer import weight_mem_pkg::*; (
	input logic clk,
	input logic reset,
	input logic fc_wr_en,
	input word_addr_t fc_wr_addr,
	input weight_word_t fc_wr_data,
	input logic cnn_wr_en,
	input word_addr_t cnn_wr_addr,
	input weight_word_t cnn_wr_data,
	input logic rd_en,
	input word_addr_t rd_addr,
	input word_addr_t weight_pointer,
	input logic [2:0] mode,
	output weight_tile_t read_word
);

	logic bank0_wr_en;
	logic bank1_wr_en;
	logic [`WB_ROW_ADDR_W-1:0] wr_row;
	logic [1:0] wr_lane;
	weight_word_t wr_data;

	logic bank0_rd_en;
	logic bank1_rd_en;
	logic [`WB_ROW_ADDR_W-1:0] rd_row;
	weight_tile_t bank0_tile;
	weight_tile_t bank1_tile;

	weight_write_arbiter i_write_arbiter (
		.clk(clk),
		.reset(reset),
		.fc_wr_en(fc_wr_en),
		.cnn_wr_en(cnn_wr_en),
		.fc_wr_addr(fc_wr_addr),
		.cnn_wr_addr(cnn_wr_addr),
		.fc_wr_data(fc_wr_data),
		.cnn_wr_data(cnn_wr_data),
		.bank0_wr_en(bank0_wr_en),
		.bank1_wr_en(bank1_wr_en),
		.wr_row(wr_row),
		.wr_lane(wr_lane),
		.wr_data(wr_data)
	);

	weight_bank bank_0 (
		.clk(clk),
		.reset(reset),
		.wr_en(bank0_wr_en),
		.wr_row(wr_row),
		.wr_lane(wr_lane),
		.wr_data(wr_data),
		.rd_en(bank0_rd_en),
		.rd_row(rd_row),
		.rd_tile(bank0_tile)
	);

	weight_bank bank_1 (
		.clk(clk),
		.reset(reset),
		.wr_en(bank1_wr_en),
		.wr_row(wr_row),
		.wr_lane(wr_lane),
		.wr_data(wr_data),
		.rd_en(bank1_rd_en),
		.rd_row(rd_row),
		.rd_tile(bank1_tile)
	);

	weight_read_ctrl i_read_ctrl (
		.clk(clk),
		.reset(reset),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.weight_pointer(weight_pointer),
		.mode(mode),
		.bank0_rd_en(bank0_rd_en),
		.bank1_rd_en(bank1_rd_en),
		.rd_row(rd_row),
		.bank0_tile(bank0_tile),
		.bank1_tile(bank1_tile),
		.read_word(read_word)
	);

endmodule

// ==== logic/weight_mem_pkg.sv ====
`include "weight_mem_defs.svh"

package weight_mem_pkg;

	// One signed weight
	typedef logic signed [`WB_WEIGHT_W-1:0] weight_t;

	// Four weights, lane 0 in the low bits
	typedef weight_t [`WB_N_DIM-1:0] weight_word_t;

	// Four words, row 0 in the low bits
	typedef weight_word_t [`WB_N_DIM-1:0] weight_tile_t;

	// Bit 11 is the bank, bits 10:2 the row, bits 1:0 the lane
	typedef logic [`WB_ADDR_W-1:0] word_addr_t;

endpackage

// ==== logic/weight_read_ctrl.sv ====
`include "weight_mem_defs.svh"

module weight_read_ctrl import weight_mem_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rd_en,
	input word_addr_t rd_addr,
	input word_addr_t weight_pointer,
	input logic [2:0] mode,
	output logic bank0_rd_en,
	output logic bank1_rd_en,
	output logic [`WB_ROW_ADDR_W-1:0] rd_row,
	input weight_tile_t bank0_tile,
	input weight_tile_t bank1_tile,
	output weight_tile_t read_word
);

	word_addr_t eff_addr;
	logic bank_sel;

	logic bank_sel_q;
	logic [1:0] lane_q;
	logic [2:0] mode_q;
	weight_tile_t sel_tile;

	assign eff_addr = rd_addr + weight_pointer; // Wraps at 4096
	assign bank_sel = eff_addr[`WB_ADDR_W-1];

	// Both modes fetch the full row, CNN picks its lane afterwards
	assign bank0_rd_en = rd_en && !bank_sel;
	assign bank1_rd_en = rd_en && bank_sel;
	assign rd_row = eff_addr[`WB_ADDR_W-2:2];

	// These line up with the bank data that returns on the next cycle
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			bank_sel_q <= 1'b0;
			lane_q <= 2'd0;
			mode_q <= `WB_MODE_FC;
		end else if (rd_en) begin
			bank_sel_q <= bank_sel;
			lane_q <= eff_addr[1:0];
			mode_q <= mode;
		end
	end

	assign sel_tile = bank_sel_q ? bank1_tile : bank0_tile;

	always_comb begin
		read_word = '0;
		case (mode_q)
			`WB_MODE_FC: begin
				read_word = sel_tile;
			end
			`WB_MODE_CNN: begin
				read_word[0] = sel_tile[lane_q]; // Rows 1 to 3 stay zero
			end
			default: begin
				read_word = '0;
			end
		endcase
	end

	a_rd_mode_legal: assert property (
		@(posedge clk) disable iff (!reset)
		rd_en |-> (mode == `WB_MODE_FC || mode == `WB_MODE_CNN)
	) else $error("weight_read_ctrl read issued with illegal mode %0d", mode);

endmodule

// ==== logic/weight_write_arbiter.sv ====
`include "weight_mem_defs.svh"

module weight_write_arbiter import weight_mem_pkg::*; (
	input logic clk,
	input logic reset,
	input logic fc_wr_en,
	input logic cnn_wr_en,
	input word_addr_t fc_wr_addr,
	input word_addr_t cnn_wr_addr,
	input weight_word_t fc_wr_data,
	input weight_word_t cnn_wr_data,
	output logic bank0_wr_en,
	output logic bank1_wr_en,
	output logic [`WB_ROW_ADDR_W-1:0] wr_row,
	output logic [1:0] wr_lane,
	output weight_word_t wr_data
);

	logic hold_valid;
	word_addr_t hold_addr;
	weight_word_t hold_data;

	logic grant_fc;
	logic grant_hold;
	logic grant_cnn;
	logic park_cnn;
	logic grant_any;
	word_addr_t grant_addr;
	weight_word_t grant_data;

	// FC always wins, a parked CNN write goes next, a fresh CNN write last
	assign grant_fc = fc_wr_en;
	assign grant_hold = hold_valid && !fc_wr_en;
	assign grant_cnn = cnn_wr_en && !fc_wr_en && !hold_valid;
	assign park_cnn = cnn_wr_en && (fc_wr_en || hold_valid); // CNN lost the port this cycle
	assign grant_any = grant_fc || grant_hold || grant_cnn;

	always_comb begin
		grant_addr = fc_wr_addr;
		grant_data = fc_wr_data;
		if (grant_hold) begin
			grant_addr = hold_addr;
			grant_data = hold_data;
		end else if (grant_cnn) begin
			grant_addr = cnn_wr_addr;
			grant_data = cnn_wr_data;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			hold_valid <= 1'b0;
		end else if (park_cnn) begin
			hold_valid <= 1'b1;
		end else if (grant_hold) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (park_cnn) begin
			hold_addr <= cnn_wr_addr;
			hold_data <= cnn_wr_data;
		end
	end

	// The address MSB steers the strobe, the rest of the write bus is shared
	assign bank0_wr_en = grant_any && !grant_addr[`WB_ADDR_W-1];
	assign bank1_wr_en = grant_any && grant_addr[`WB_ADDR_W-1];
	assign wr_row = grant_addr[`WB_ADDR_W-2:2];
	assign wr_lane = grant_addr[1:0];
	assign wr_data = grant_data;

	// A second collision before the parked write drains would lose a write
	a_no_hold_overflow: assert property (
		@(posedge clk) disable iff (!reset)
		hold_valid |-> !(fc_wr_en && cnn_wr_en)
	) else $error("weight_write_arbiter collision while the CNN hold register is full");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_weight_buffer \
	-f weight_buffer.f \
	-o tb_weight_buffer
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/tb_weight_buffer)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -F -q "*** TEST PASSED ***"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== sim/tb_weight_buffer.sv ====
`include "weight_mem_defs.svh"

module tb_weight_buffer import weight_mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic reset;
	logic fc_wr_en;
	word_addr_t fc_wr_addr;
	weight_word_t fc_wr_data;
	logic cnn_wr_en;
	word_addr_t cnn_wr_addr;
	weight_word_t cnn_wr_data;
	logic rd_en;
	word_addr_t rd_addr;
	word_addr_t weight_pointer;
	logic [2:0] mode;
	weight_tile_t read_word;

	weight_word_t shadow [1 << `WB_ADDR_W]; // What the buffer should hold
	weight_tile_t exp_q [$];
	weight_tile_t exp_tile;
	logic rd_seen;
	logic drain_timeout;
	logic [31:0] lfsr_state;

	int tests_done;
	int checks;
	int errors;
	int checks_start;
	int errors_start;

	weight_buffer i_weight_buffer (
		.clk(clk),
		.reset(reset),
		.fc_wr_en(fc_wr_en),
		.fc_wr_addr(fc_wr_addr),
		.fc_wr_data(fc_wr_data),
		.cnn_wr_en(cnn_wr_en),
		.cnn_wr_addr(cnn_wr_addr),
		.cnn_wr_data(cnn_wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.weight_pointer(weight_pointer),
		.mode(mode),
		.read_word(read_word)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Taps 32, 22, 2 and 1
	function automatic logic lfsr_next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic word_addr_t rand_addr();
		word_addr_t a;
		a = '0;
		for (int i = 0; i < `WB_ADDR_W; i++) begin
			a = {a[`WB_ADDR_W-2:0], lfsr_next_bit()};
		end
		return a;
	endfunction

	function automatic weight_word_t rand_word();
		logic [31:0] d;
		d = '0;
		for (int i = 0; i < 32; i++) begin
			d = {d[30:0], lfsr_next_bit()};
		end
		return d;
	endfunction

	// FC returns the aligned group of four words, CNN one word in row 0
	function automatic weight_tile_t ref_tile(input word_addr_t addr, input word_addr_t ptr,
			input logic [2:0] md);
		word_addr_t eff;
		weight_tile_t tile;
		eff = addr + ptr; // The 12-bit sum wraps at 4096
		tile = '0;
		if (md == `WB_MODE_FC) begin
			tile[0] = shadow[{eff[11:2], 2'd0}];
			tile[1] = shadow[{eff[11:2], 2'd1}];
			tile[2] = shadow[{eff[11:2], 2'd2}];
			tile[3] = shadow[{eff[11:2], 2'd3}];
		end else if (md == `WB_MODE_CNN) begin
			tile[0] = shadow[eff];
		end
		return tile;
	endfunction

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			rd_seen <= 1'b0;
		end else begin
			rd_seen <= rd_en;
		end
	end

	// Data of a read sampled at the last rising edge is settled by the falling edge
	always @(negedge clk) begin
		if (rd_seen) begin
			assert (exp_q.size() != 0) else begin
				$display("read data returned with no read outstanding");
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_tile = exp_q.pop_front();
				checks++;
				assert (read_word === exp_tile) else begin
					$display("error read_word expected %h actual %h", exp_tile, read_word);
					errors++;
				end
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic finish_run(input logic timed_out);
		$display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	task automatic report_test(input string name);
		tests_done++;
		$display("%s done: %0d checks, %0d errors", name, checks - checks_start,
			errors - errors_start);
		checks_start = checks;
		errors_start = errors;
	endtask

	task automatic fc_write(input word_addr_t addr, input weight_word_t data);
		fc_wr_en = 1'b1;
		fc_wr_addr = addr;
		fc_wr_data = data;
		shadow[addr] = data;
		next_cycle();
		fc_wr_en = 1'b0;
	endtask

	task automatic cnn_write(input word_addr_t addr, input weight_word_t data);
		cnn_wr_en = 1'b1;
		cnn_wr_addr = addr;
		cnn_wr_data = data;
		shadow[addr] = data;
		next_cycle();
		cnn_wr_en = 1'b0;
	endtask

	task automatic drive_read(input word_addr_t addr, input word_addr_t ptr,
			input logic [2:0] md);
		rd_en = 1'b1;
		rd_addr = addr;
		weight_pointer = ptr;
		mode = md;
		exp_q.push_back(ref_tile(addr, ptr, md));
	endtask

	task automatic read_once(input word_addr_t addr, input word_addr_t ptr,
			input logic [2:0] md);
		drive_read(addr, ptr, md);
		next_cycle();
		rd_en = 1'b0;
	endtask

	task automatic wait_reads_drained(input string name);
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 16) begin
			next_cycle();
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("%s timed out with %0d reads still waiting for data", name, exp_q.size());
			drain_timeout = 1'b1;
			exp_q.delete();
		end
	endtask

	task automatic check_after_reset();
		word_addr_t fill_addr;
		checks++;
		assert (read_word === '0) else begin
			$display("error read_word expected %h actual %h", weight_tile_t'(0), read_word);
			errors++;
		end
		fc_wr_en = 1'b1;
		fc_wr_data = '0;
		for (int i = 0; i < (1 << `WB_ADDR_W); i++) begin
			fill_addr = word_addr_t'(i);
			fc_wr_addr = fill_addr;
			shadow[fill_addr] = '0;
			next_cycle();
		end
		fc_wr_en = 1'b0;
		for (int i = 0; i < 8; i++) begin
			read_once(rand_addr(), '0, i[0] ? `WB_MODE_CNN : `WB_MODE_FC);
		end
		wait_reads_drained("check_after_reset");
		report_test("check_after_reset");
	endtask

	task automatic fc_tile_roundtrip();
		word_addr_t bases [$];
		word_addr_t base;
		for (int t = 0; t < 24; t++) begin
			base = rand_addr();
			base[11] = t[0]; // Tiles alternate between the banks
			base[1:0] = 2'd0;
			bases.push_back(base);
			for (int w = 0; w < `WB_N_DIM; w++) begin
				fc_write({base[11:2], 2'(w)}, rand_word());
			end
		end
		for (int t = 0; t < bases.size(); t++) begin
			read_once(bases[t], '0, `WB_MODE_FC);
		end
		for (int t = 0; t < 8; t++) begin
			read_once(rand_addr(), '0, `WB_MODE_FC);
		end
		wait_reads_drained("fc_tile_roundtrip");
		report_test("fc_tile_roundtrip");
	endtask

	task automatic cnn_lane_roundtrip();
		word_addr_t bases [$];
		word_addr_t base;
		for (int r = 0; r < 8; r++) begin
			base = rand_addr();
			bases.push_back(base);
			for (int lane = 0; lane < `WB_N_DIM; lane++) begin
				cnn_write({base[11:2], 2'(lane)}, rand_word());
			end
		end
		for (int r = 0; r < bases.size(); r++) begin
			base = bases[r];
			for (int lane = 0; lane < `WB_N_DIM; lane++) begin
				read_once({base[11:2], 2'(lane)}, '0, `WB_MODE_CNN);
			end
		end
		wait_reads_drained("cnn_lane_roundtrip");
		report_test("cnn_lane_roundtrip");
	endtask

	task automatic pointer_wraparound();
		word_addr_t addrs [$];
		word_addr_t ptr;
		word_addr_t addr;
		word_addr_t eff;
		ptr = rand_addr() | 12'hc00;
		for (int i = 0; i < 16; i++) begin
			if (i[0]) begin
				addr = rand_addr() & 12'h0ff;
			end else begin
				addr = rand_addr() | 12'h400; // Sum with the pointer passes 4095
			end
			addrs.push_back(addr);
			eff = addr + ptr;
			fc_write(eff, rand_word());
		end
		for (int i = 0; i < addrs.size(); i++) begin
			read_once(addrs[i], ptr, i[1] ? `WB_MODE_CNN : `WB_MODE_FC);
		end
		wait_reads_drained("pointer_wraparound");
		report_test("pointer_wraparound");
	endtask

	task automatic simultaneous_writes();
		word_addr_t fc_addr;
		word_addr_t cnn_addr;
		word_addr_t flip;
		for (int i = 0; i < 8; i++) begin
			fc_addr = rand_addr();
			flip = rand_addr();
			flip[0] = 1'b1;
			cnn_addr = fc_addr ^ flip; // Never equal to the FC address
			fc_wr_en = 1'b1;
			fc_wr_addr = fc_addr;
			fc_wr_data = rand_word();
			cnn_wr_en = 1'b1;
			cnn_wr_addr = cnn_addr;
			cnn_wr_data = rand_word();
			shadow[fc_addr] = fc_wr_data;
			shadow[cnn_addr] = cnn_wr_data;
			next_cycle();
			fc_wr_en = 1'b0;
			cnn_wr_en = 1'b0;
			next_cycle();
			next_cycle();
			read_once(fc_addr, '0, `WB_MODE_CNN);
			read_once(cnn_addr, '0, `WB_MODE_CNN);
			read_once(cnn_addr, '0, `WB_MODE_FC);
		end
		wait_reads_drained("simultaneous_writes");
		report_test("simultaneous_writes");
	endtask

	task automatic back_to_back_reads();
		word_addr_t addrs [$];
		word_addr_t addr;
		for (int i = 0; i < 24; i++) begin
			addr = rand_addr();
			addr[11] = i[0];
			addrs.push_back(addr);
			fc_write(addr, rand_word()); // Every read below lands on a written word
		end
		for (int i = 0; i < addrs.size(); i++) begin
			drive_read(addrs[i], '0, i[1] ? `WB_MODE_CNN : `WB_MODE_FC);
			next_cycle();
		end
		rd_en = 1'b0;
		wait_reads_drained("back_to_back_reads");
		report_test("back_to_back_reads");
	endtask

	initial begin
		lfsr_state = 32'ha9e4;
		tests_done = 0;
		checks = 0;
		errors = 0;
		checks_start = 0;
		errors_start = 0;
		drain_timeout = 1'b0;
		reset = 1'b0;
		fc_wr_en = 1'b0;
		fc_wr_addr = '0;
		fc_wr_data = '0;
		cnn_wr_en = 1'b0;
		cnn_wr_addr = '0;
		cnn_wr_data = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		weight_pointer = '0;
		mode = `WB_MODE_FC;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b1;
		next_cycle();
		check_after_reset();
		fc_tile_roundtrip();
		cnn_lane_roundtrip();
		pointer_wraparound();
		simultaneous_writes();
		back_to_back_reads();
		finish_run(drain_timeout);
	end

endmodule

// ==== weight_buffer.f ====
+incdir+include
logic/weight_mem_pkg.sv
logic/weight_bank.sv
logic/weight_write_arbiter.sv
logic/weight_read_ctrl.sv
logic/weight_buffer.sv
sim/tb_weight_buffer.sv
